// File: filelist.f
+incdir+tb
verilog/decim_pkg.sv
verilog/channel_accumulator.sv
verilog/window_reducer.sv
verilog/standard_decimator.sv
tb/standard_decimator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the decimator testbench with Verilator and run it
# Exit status is nonzero when the testbench reports a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module standard_decimator_tb \
    -f filelist.f \
    -o standard_decimator_tb

./obj_dir/standard_decimator_tb

// File: tb/decimator_model.svh
//////////////////////////////////////////////////
// LFSR step and reference model of the decimator
//////////////////////////////////////////////////

`ifndef DECIMATOR_MODEL_SVH
`define DECIMATOR_MODEL_SVH

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

// One window per channel
int m_sum   [decim_pkg::n_channels];
int m_count [decim_pkg::n_channels];

// Ratio the DUT works with in the cycle being driven
int m_ratio;

// Expected outputs in the order they leave the DUT
decim_pkg::stream_sample_t exp_q[$];

task automatic model_clear();
    for (int i = 0; i < decim_pkg::n_channels; i++) begin
        m_sum[i] = 0;
        m_count[i] = 0;
    end
endtask

// Division that rounds toward minus infinity
function automatic int floor_average(input int sum, input int k);
    int len;
    int q;
    len = 1 << k;
    q = sum / len;
    if ((sum % len != 0) && (sum < 0)) begin
        q = q - 1;
    end
    return q;
endfunction

// Accepted sample, queues an output when its window fills
task automatic model_sample(input int dest, input int data, input bit avg, output bit done);
    decim_pkg::stream_sample_t expected;
    done = 1'b0;
    m_sum[dest] += data;
    m_count[dest] += 1;
    if (m_count[dest] == (1 << m_ratio)) begin
        expected.data = avg ? 16'(floor_average(m_sum[dest], m_ratio)) : 16'(data);
        expected.dest = 3'(dest);
        exp_q.push_back(expected);
        m_sum[dest] = 0;
        m_count[dest] = 0;
        done = 1'b1;
    end
endtask

`endif

// File: tb/standard_decimator_tb.sv
//////////////////////////////////////////////////
// Decimator testbench with random traffic against a model
//////////////////////////////////////////////////

`timescale 1ns/100ps

module standard_decimator_tb;

    logic                                   clock;
    logic                                   arst_n;
    decim_pkg::stream_sample_t              in_sample;
    logic                                   in_valid;
    logic [decim_pkg::ratio_log2_width-1:0] ratio_log2;
    logic                                   average_en;
    decim_pkg::stream_sample_t              out_sample;
    logic                                   out_valid;

    // Completion flag sent with each beat and its copy two cycles later
    logic        complete_tag;
    logic        tag_d1;
    logic        tag_d2;

    logic [31:0] lfsr_state;
    int          cur_ratio;
    bit          cur_avg;

    `include "decimator_model.svh"

    standard_decimator dut_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .ratio_log2 (ratio_log2),
        .average_en (average_en),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    // Output must follow its completing input by exactly two cycles
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tag_d1 <= 1'b0;
            tag_d2 <= 1'b0;
        end else begin
            tag_d1 <= complete_tag;
            tag_d2 <= tag_d1;
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at %0t: %s is %0h, expected %0h",
                                     $time, name, actual, expected));
        end
    endtask

    // Outputs sampled at the falling edge away from the DUT updates
    always @(negedge clock) begin : monitor
        decim_pkg::stream_sample_t expected;
        if (arst_n) begin
            check_value("out_valid", 32'(out_valid), 32'(tag_d2));
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("Output sample arrived with nothing expected");
                end else begin
                    expected = exp_q.pop_front();
                    check_value("out_sample.data", 32'(out_sample.data), 32'(expected.data));
                    check_value("out_sample.dest", 32'(out_sample.dest), 32'(expected.dest));
                end
            end
        end
    end

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // One beat on the rising edge with the model stepping on the same beat
    task automatic send(input bit valid, input int dest, input int data);
        bit done;
        done = 1'b0;
        if (cur_ratio != m_ratio) begin
            // DUT sees a new ratio this cycle and drops the sample and all windows
            model_clear();
        end else if (valid && dest < decim_pkg::n_channels) begin
            model_sample(dest, data, cur_avg, done);
        end
        m_ratio = cur_ratio;
        @(posedge clock);
        in_valid       <= valid;
        in_sample.data <= 16'(data);
        in_sample.dest <= 3'(dest);
        ratio_log2     <= 3'(cur_ratio);
        average_en     <= cur_avg;
        complete_tag   <= done;
    endtask

    // Random beats with about one idle cycle in four
    task automatic random_traffic(input int beats, input int dest_bits);
        logic [31:0] gap;
        logic [31:0] dest;
        logic [31:0] data;
        for (int i = 0; i < beats; i++) begin
            draw_bits(2, gap);
            if (gap == 0) begin
                send(1'b0, 0, 0);
            end
            draw_bits(dest_bits, dest);
            draw_bits(16, data);
            send(1'b1, int'(dest), int'($signed(data[15:0])));
        end
    endtask

    // Idle first so a window still in the reducer keeps its ratio
    task automatic change_ratio(input int k);
        logic [31:0] data;
        send(1'b0, 0, 0);
        cur_ratio = k;
        draw_bits(16, data);
        send(1'b1, 0, int'($signed(data[15:0])));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 40) begin
            send(1'b0, 0, 0);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_failure("Timed out waiting for the expected output samples");
        end
    endtask

    initial begin : stimulus
        logic [31:0] data;
        lfsr_state   = 32'hb7e76172;
        cur_ratio    = 2;
        cur_avg      = 1'b1;
        m_ratio      = cur_ratio;
        model_clear();
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_sample    = '0;
        ratio_log2   = 3'(cur_ratio);
        average_en   = cur_avg;
        complete_tag = 1'b0;
        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
        send(1'b0, 0, 0);
        send(1'b0, 0, 0);

        // Averaging over windows of 4 on channels 0 to 3
        random_traffic(80, 2);
        drain();

        // Two ratio changes clear the partial windows left by the random traffic
        change_ratio(1);
        change_ratio(2);

        // Full scale and then negative windows
        repeat (4) send(1'b1, 1, 32767);
        repeat (4) send(1'b1, 1, -32768);
        send(1'b1, 2, -10);
        send(1'b1, 2, -7);
        send(1'b1, 2, -3);
        send(1'b1, 2, 4);
        send(1'b1, 3, -10);
        send(1'b1, 3, -7);
        send(1'b1, 3, -3);
        send(1'b1, 3, 5);
        drain();

        // Plain decimation at every ratio
        cur_avg = 1'b0;
        for (int k = 0; k <= decim_pkg::max_ratio_log2; k++) begin
            change_ratio(k);
            random_traffic((8 << k) + 24, 2);
            drain();
        end

        // Back-to-back completions at ratio 1 and then interleaved windows of 4
        cur_avg = 1'b1;
        change_ratio(0);
        random_traffic(60, 2);
        change_ratio(2);
        for (int r = 0; r < 4; r++) begin
            for (int ch = 0; ch < decim_pkg::n_channels; ch++) begin
                draw_bits(16, data);
                send(1'b1, ch, int'($signed(data[15:0])));
            end
        end
        drain();

        // Full dest range where 4 to 7 must vanish
        random_traffic(120, 3);
        drain();

        // Ratio changes in the middle of windows
        change_ratio(3);
        random_traffic(30, 3);
        change_ratio(1);
        random_traffic(40, 2);
        change_ratio(4);
        random_traffic(50, 2);
        change_ratio(2);
        random_traffic(40, 2);
        drain();

        repeat (4) send(1'b0, 0, 0);
        if (exp_q.size() != 0) begin
            report_failure("Expected samples were left over at the end of the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: verilog/channel_accumulator.sv
//////////////////////////////////////////////////
// Per-channel window sums, sample counters and window-complete detection
//////////////////////////////////////////////////

`timescale 1ns/100ps

module channel_accumulator (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  decim_pkg::stream_sample_t                  in_sample,
    input  logic                                       in_valid,
    input  logic [decim_pkg::ratio_log2_width-1:0]     ratio_log2,
    output decim_pkg::window_t                         win,
    output logic                                       win_valid
);

    // Per-channel running state
    logic signed [decim_pkg::sum_width-1:0]  sum_q   [decim_pkg::n_channels];
    logic [decim_pkg::count_width-1:0]       count_q [decim_pkg::n_channels];

    // Registered ratio is compared against the live input to spot a change
    logic [decim_pkg::ratio_log2_width-1:0]  ratio_q;
    logic                                    ratio_change;

    logic                                    chan_ok;
    logic                                    accept;
    logic                                    complete;
    logic [decim_pkg::chan_idx_width-1:0]    ch;
    logic signed [decim_pkg::sum_width-1:0]  data_ext;
    logic signed [decim_pkg::sum_width-1:0]  sum_next;
    logic [decim_pkg::count_width-1:0]       count_next;
    logic [decim_pkg::count_width-1:0]       window_len;

    // Ratio change flushes every window
    assign ratio_change = (ratio_log2 != ratio_q);

    // Drop dest numbers beyond the processed channels
    assign chan_ok = (in_sample.dest < decim_pkg::n_channels);

    // Samples arriving with a new ratio are discarded along with the partial windows
    assign accept = in_valid && chan_ok && !ratio_change;

    assign ch = in_sample.dest[decim_pkg::chan_idx_width-1:0];

    // Sign extend the sample to sum width
    assign data_ext = {{decim_pkg::max_ratio_log2{in_sample.data[decim_pkg::sample_width-1]}},
                       in_sample.data};

    // State is read combinationally so back-to-back samples on one channel chain up
    assign sum_next   = sum_q[ch] + data_ext;
    assign count_next = count_q[ch] + 1'b1;

    // Window length is 2^ratio
    assign window_len = decim_pkg::count_width'(1) << ratio_q;

    assign complete = accept && (count_next == window_len);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ratio_q <= '0;
        end else begin
            ratio_q <= ratio_log2;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < decim_pkg::n_channels; i++) begin
                sum_q[i]   <= '0;
                count_q[i] <= '0;
            end
        end else if (ratio_change) begin
            // Discard all partial windows
            for (int i = 0; i < decim_pkg::n_channels; i++) begin
                sum_q[i]   <= '0;
                count_q[i] <= '0;
            end
        end else if (accept) begin
            if (complete) begin
                // Window handed off so this channel restarts
                sum_q[ch]   <= '0;
                count_q[ch] <= '0;
            end else begin
                sum_q[ch]   <= sum_next;
                count_q[ch] <= count_next;
            end
        end
    end

    // Completion strobe one cycle after the last sample
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= complete;
        end
    end

    // Window payload
    // the completing sample is also the last of the window
    always_ff @(posedge clock) begin
        if (complete) begin
            win.sum  <= sum_next;
            win.last <= in_sample.data;
            win.dest <= in_sample.dest;
        end
    end

    // Ratio beyond 16 would overflow the sum and the counter
    ratio_range_a: assert property (
        @(posedge clock) disable iff (!arst_n)
        ratio_log2 <= decim_pkg::max_ratio_log2
    );

    // Same channel completing twice in a row only happens with windows of one sample
    win_repeat_a: assert property (
        @(posedge clock) disable iff (!arst_n)
        win_valid && $past(win_valid) && (win.dest == $past(win.dest))
        |-> ($past(ratio_q) == '0)
    );

endmodule

// File: verilog/decim_pkg.sv
//////////////////////////////////////////////////
// Decimator widths, channel count and stream structs
//////////////////////////////////////////////////

package decim_pkg;

    // Sample data width, signed two's complement
    localparam int sample_width = 16;

    // Channel number width, addresses up to 8 channels
    localparam int dest_width = 3;

    // Channels actually processed
    // Any dest at or above this is dropped
    localparam int n_channels = 4;

    // Index width into the per-channel state arrays
    localparam int chan_idx_width = $clog2(n_channels);

    // Configured ratio exponent, legal values 0 to 4
    localparam int ratio_log2_width = 3;
    localparam int max_ratio_log2 = 4;

    // Window sum holds 2^max_ratio_log2 full-scale samples without overflow
    localparam int sum_width = sample_width + max_ratio_log2;

    // Sample counter reaches 2^max_ratio_log2, one bit wider than the exponent
    localparam int count_width = max_ratio_log2 + 1;

    // Input and output stream beat
    typedef struct packed {
        logic signed [sample_width-1:0] data;
        logic [dest_width-1:0]          dest;
    } stream_sample_t;

    // Completed window handed from the accumulator to the reducer
    typedef struct packed {
        logic signed [sum_width-1:0]    sum;
        logic signed [sample_width-1:0] last;
        logic [dest_width-1:0]          dest;
    } window_t;

endpackage

// File: verilog/standard_decimator.sv
//////////////////////////////////////////////////
// Decimator top, accumulator feeding the reducer
//////////////////////////////////////////////////

`timescale 1ns/100ps

module standard_decimator (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  decim_pkg::stream_sample_t                  in_sample,
    input  logic                                       in_valid,
    input  logic [decim_pkg::ratio_log2_width-1:0]     ratio_log2,
    input  logic                                       average_en,
    output decim_pkg::stream_sample_t                  out_sample,
    output logic                                       out_valid
);

    // Completed window between the two stages
    decim_pkg::window_t win;
    logic               win_valid;

    // Stage 1
    // per-channel sums, window complete one cycle after the last sample
    channel_accumulator accumulator_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .ratio_log2 (ratio_log2),
        .win        (win),
        .win_valid  (win_valid)
    );

    // Stage 2
    // average or last sample, output two cycles after the completing input
    window_reducer reducer_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .win        (win),
        .win_valid  (win_valid),
        .ratio_log2 (ratio_log2),
        .average_en (average_en),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

endmodule

// File: verilog/window_reducer.sv
//////////////////////////////////////////////////
// Window to sample reduction, average or last sample
//////////////////////////////////////////////////

`timescale 1ns/100ps

module window_reducer (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  decim_pkg::window_t                         win,
    input  logic                                       win_valid,
    input  logic [decim_pkg::ratio_log2_width-1:0]     ratio_log2,
    input  logic                                       average_en,
    output decim_pkg::stream_sample_t                  out_sample,
    output logic                                       out_valid
);

    // Full-width shifted sum, upper bits only carry sign
    logic signed [decim_pkg::sum_width-1:0]    avg_full;
    logic signed [decim_pkg::sample_width-1:0] avg;
    logic signed [decim_pkg::sample_width-1:0] result;

    // Floor average
    // arithmetic shift rounds toward minus infinity
    assign avg_full = win.sum >>> ratio_log2;

    // Sum of 2^k samples shifted by k always fits a sample
    assign avg = avg_full[decim_pkg::sample_width-1:0];

    // Plain decimation keeps the last sample of the window
    assign result = average_en ? avg : win.last;

    // Output strobe trails win_valid by one cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= win_valid;
        end
    end

    // Output payload
    always_ff @(posedge clock) begin
        if (win_valid) begin
            out_sample.data <= result;
            out_sample.dest <= win.dest;
        end
    end

    // Accumulator only sums whole windows, so truncation never drops magnitude
    avg_fits_a: assert property (
        @(posedge clock) disable iff (!arst_n)
        win_valid && average_en
        |-> (avg_full[decim_pkg::sum_width-1:decim_pkg::sample_width-1] == '0) ||
            (avg_full[decim_pkg::sum_width-1:decim_pkg::sample_width-1] == '1)
    );

endmodule
